/* corr_accumulate.sv */
`include "corr_consts.svh"

module corr_accumulate (
   input  logic             clk_x,
   input  logic             rst,
   input  logic             go,
   input  logic             clr,
   input  logic             ar,
   input  logic             br,
   input  logic             bi,
   input  corr_pkg::accum_t dcos,
   input  corr_pkg::accum_t dsin,
   output corr_pkg::accum_t qcos,
   output corr_pkg::accum_t qsin,
   output logic             overflow_cos,
   output logic             overflow_sin
);
   import corr_pkg::*;

   localparam int AW = `CORR_ACCUM_BITS;

   logic          go_q;
   logic          clr_q;
   logic          match_cos;
   logic          match_sin;
   accum_t        base_cos;
   accum_t        base_sin;
   logic [AW:0]   sum_cos;
   logic [AW:0]   sum_sin;

   // ----------------------------------------
   // Operand stage
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         go_q  <= 1'b0;
         clr_q <= 1'b0;
      end else begin
         go_q  <= go;
         clr_q <= clr;
      end
   end

   always_ff @(posedge clk_x) begin
      if (go) begin
         // Sign bits agree
         match_cos <= ~(ar ^ br);
         match_sin <= ~(ar ^ bi);
         // Zero input restarts the pair after a bank switch
         base_cos  <= clr ? '0 : dcos;
         base_sin  <= clr ? '0 : dsin;
      end
   end

   // Extra bit catches the carry out
   assign sum_cos = {1'b0, base_cos} + match_cos;
   assign sum_sin = {1'b0, base_sin} + match_sin;

   // ----------------------------------------
   // Sum stage
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (go_q) begin
         qcos <= sum_cos[AW-1:0];
         qsin <= sum_sin[AW-1:0];
      end
   end

   // Sticky until a clearing sweep
   always_ff @(posedge clk_x) begin
      if (rst) begin
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else if (go_q && clr_q) begin
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else if (go_q) begin
         if (sum_cos[AW]) begin
            overflow_cos <= 1'b1;
         end
         if (sum_sin[AW]) begin
            overflow_sin <= 1'b1;
         end
      end
   end

endmodule

/* corr_assertions.sv */
`include "corr_consts.svh"

module corr_assertions (
   input logic            clk_x,
   input logic            rst,
   input logic            slot_en,
   input corr_pkg::slot_t rd_slot,
   input logic            vis_valid,
   input corr_pkg::slot_t vis_slot,
   input logic            sweep_clr
);

   // ----------------------------------------
   // Sweep length
   // ----------------------------------------
   // One enable burst per sweep with one cycle per pair
   slot_en_length: assert property (
      @(posedge clk_x) disable iff (rst)
      $rose(slot_en) |-> slot_en [*`CORR_SLOTS] ##1 !slot_en
   ) else $error("slot_en burst is not %0d cycles long", `CORR_SLOTS);

   // ----------------------------------------
   // Pipeline alignment
   // ----------------------------------------
   // Counter write address lines up with the datapath valid
   valid_after_enable: assert property (
      @(posedge clk_x) disable iff (rst)
      slot_en |-> ##2 (vis_valid && (vis_slot == $past(rd_slot, 2)))
   ) else $error("vis_valid or vis_slot not aligned two cycles after slot_en");

   // Clear level is fixed for the whole sweep
   clr_stable_in_sweep: assert property (
      @(posedge clk_x) disable iff (rst)
      (slot_en && $past(slot_en)) |-> $stable(sweep_clr)
   ) else $error("sweep_clr changed in the middle of a sweep");

endmodule

// Datapath sees the controller clear level and the counter enable
bind correlator_block corr_assertions u_corr_assertions (
   .clk_x     (clk_x),
   .rst       (rst),
   .slot_en   (slot_en),
   .rd_slot   (rd_slot),
   .vis_valid (vis_valid),
   .vis_slot  (vis_slot),
   .sweep_clr (sweep_clr)
);

/* corr_consts.svh */
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// ----------------------------------------
// Array size and accumulator geometry
// ----------------------------------------
`define CORR_ANTENNAS    24
`define CORR_ACCUM_BITS  8

// One slot per antenna pair
`define CORR_SLOTS       12
`define CORR_SLOT_BITS   4

// ----------------------------------------
// Pair table, 10 bits per slot, slot 0 in the low bits
// ----------------------------------------
// Each entry is {b, a} as two 5-bit antenna indices
// Slots 11..0 are (21,23) (17,20) (15,16) (13,14) (11,12) (9,10)
// (7,8) (5,6) (3,4) (1,2) (0,2) (0,1)
`define CORR_PAIRS {5'd23, 5'd21, 5'd20, 5'd17, 5'd16, 5'd15, 5'd14, 5'd13, \
                    5'd12, 5'd11, 5'd10, 5'd9,  5'd8,  5'd7,  5'd6,  5'd5,  \
                    5'd4,  5'd3,  5'd2,  5'd1,  5'd2,  5'd0,  5'd1,  5'd0}

`endif

/* corr_ctrl_fsm.sv */
module corr_ctrl_fsm (
   input  logic              clk_x,
   input  logic              rst,
   input  logic              sample_strb,
   input  corr_pkg::sample_t sample_in,
   input  logic              bank_sw,
   input  logic              sweep_done,
   output logic              sweep_start,
   output logic              sweep_clr,
   output corr_pkg::sample_t held_sample,
   output logic              missed
);
   import corr_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_next;
   logic        clr_pending;
   logic        accept;

   // Strobe is taken when idle, or on the last slot of a running sweep
   assign accept = sample_strb && ((state == IDLE) || sweep_done);

   // ----------------------------------------
   // Next state
   // ----------------------------------------
   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (accept) begin
               state_next = SWEEP;
            end
         end
         SWEEP: begin
            // Back-to-back strobe keeps the machine in SWEEP
            if (sweep_done && !accept) begin
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   // ----------------------------------------
   // Control registers
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state       <= IDLE;
         sweep_start <= 1'b0;
         sweep_clr   <= 1'b0;
         clr_pending <= 1'b0;
         missed      <= 1'b0;
      end else begin
         state       <= state_next;
         sweep_start <= accept;
         if (accept) begin
            // Switch pulse in the same cycle joins this sweep
            sweep_clr   <= clr_pending | bank_sw;
            clr_pending <= 1'b0;
         end else begin
            // Clear level ends with its sweep
            if (sweep_done) begin
               sweep_clr <= 1'b0;
            end
            if (bank_sw) begin
               clr_pending <= 1'b1;
            end
         end
         // Sticky, strobe dropped mid-sweep
         if (sample_strb && !accept) begin
            missed <= 1'b1;
         end
      end
   end

   // Sample bits held for the whole sweep
   always_ff @(posedge clk_x) begin
      if (accept) begin
         held_sample <= sample_in;
      end
   end

endmodule

/* corr_pkg.sv */
`include "corr_consts.svh"

package corr_pkg;

   // ----------------------------------------
   // Plain vector types
   // ----------------------------------------
   // One sign bit per antenna
   typedef logic [`CORR_ANTENNAS-1:0] ant_vec_t;

   // Slot index within a sweep
   typedef logic [`CORR_SLOT_BITS-1:0] slot_t;

   // One cos or sin accumulator
   typedef logic [`CORR_ACCUM_BITS-1:0] accum_t;

   // Antenna index into ant_vec_t
   typedef logic [$clog2(`CORR_ANTENNAS)-1:0] ant_idx_t;

   // ----------------------------------------
   // Grouped signals
   // ----------------------------------------
   // Real and imaginary sign bits of one sample strobe
   typedef struct packed {
      ant_vec_t re;
      ant_vec_t im;
   } sample_t;

   // Visibility word, sin in the upper half
   typedef struct packed {
      accum_t sin;
      accum_t cos;
   } vis_t;

   // One pair table entry, b above a
   typedef struct packed {
      ant_idx_t b;
      ant_idx_t a;
   } pair_t;

   // Controller states
   typedef enum logic {
      IDLE,
      SWEEP
   } ctrl_state_t;

endpackage

/* corr_slot_counter.sv */
`include "corr_consts.svh"

module corr_slot_counter (
   input  logic            clk_x,
   input  logic            rst,
   input  logic            sweep_start,
   output corr_pkg::slot_t rd_slot,
   output logic            slot_en,
   output corr_pkg::slot_t wr_slot,
   output logic            sweep_done
);
   import corr_pkg::*;

   localparam slot_t LAST_SLOT = slot_t'(`CORR_SLOTS - 1);

   // First stage of the write address delay
   slot_t rd_slot_q;

   // ----------------------------------------
   // Read slot counter
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         rd_slot <= '0;
         slot_en <= 1'b0;
      end else if (sweep_start) begin
         rd_slot <= '0;
         slot_en <= 1'b1;
      end else if (slot_en) begin
         if (rd_slot == LAST_SLOT) begin
            // Stop by itself after the last pair
            rd_slot <= '0;
            slot_en <= 1'b0;
         end else begin
            rd_slot <= rd_slot + 1'b1;
         end
      end
   end

   assign sweep_done = slot_en && (rd_slot == LAST_SLOT);

   // Two stages to match read, add, write-back
   always_ff @(posedge clk_x) begin
      if (rst) begin
         rd_slot_q <= '0;
         wr_slot   <= '0;
      end else begin
         rd_slot_q <= rd_slot;
         wr_slot   <= rd_slot_q;
      end
   end

endmodule

/* corr_tb.sv */
`include "corr_consts.svh"

module corr_tb;
   import corr_pkg::*;

   localparam int SLOTS   = `CORR_SLOTS;
   localparam int ACC_MOD = 1 << `CORR_ACCUM_BITS;
   localparam logic [SLOTS*10-1:0] PAIR_TABLE = `CORR_PAIRS;

   // Expected output word with the flags that go with it
   typedef struct packed {
      slot_t slot;
      logic  ovf_cos;
      logic  ovf_sin;
      vis_t  word;
   } exp_word_t;

   logic        clk_x;
   logic        rst;
   logic        sample_strb;
   sample_t     sample_in;
   logic        bank_sw;
   logic        vis_valid;
   slot_t       vis_slot;
   vis_t        vis;
   logic        overflow_cos;
   logic        overflow_sin;
   logic        missed;

   exp_word_t   exp_q[$];
   string       trace_lines[$];
   int          ref_cos [0:SLOTS-1];
   int          ref_sin [0:SLOTS-1];
   logic        ref_ovf_cos;
   logic        ref_ovf_sin;
   logic        exp_missed;
   accum_t      seen_cos [0:SLOTS-1];
   accum_t      seen_sin [0:SLOTS-1];
   logic [16:0] lfsr_state;
   int          errors;
   int          checks;
   int          words_seen;
   int          sweeps;
   int          cycles;
   int          cycle_limit;

   corr_top u_corr_top (
      .clk_x        (clk_x),
      .rst          (rst),
      .sample_strb  (sample_strb),
      .sample_in    (sample_in),
      .bank_sw      (bank_sw),
      .vis_valid    (vis_valid),
      .vis_slot     (vis_slot),
      .vis          (vis),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin),
      .missed       (missed)
   );

   always #10 clk_x = ~clk_x;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // Fibonacci LFSR x^17 + x^14 + 1 stepped once per bit
   function automatic logic random_bit();
      logic fb;
      fb = lfsr_state[16] ^ lfsr_state[13];
      lfsr_state = {lfsr_state[15:0], fb};
      return fb;
   endfunction

   function automatic sample_t random_sample(input logic [23:0] mask);
      logic [47:0] bits;
      sample_t     s;
      for (int i = 0; i < 48; i++) begin
         bits[i] = random_bit();
      end
      s.re = bits[47:24] & mask;
      s.im = bits[23:0] & mask;
      return s;
   endfunction

   // Match-count rule over the pair table with one word per slot
   function automatic void model_sweep(input sample_t s, input logic clr);
      logic [9:0] entry;
      int         a;
      int         b;
      int         sum_c;
      int         sum_s;
      exp_word_t  e;
      for (int slot = 0; slot < SLOTS; slot++) begin
         // Entry is {b, a}
         entry = PAIR_TABLE[slot*10 +: 10];
         a = entry[4:0];
         b = entry[9:5];
         if (clr) begin
            ref_cos[slot] = 0;
            ref_sin[slot] = 0;
            ref_ovf_cos   = 1'b0;
            ref_ovf_sin   = 1'b0;
         end
         sum_c = ref_cos[slot] + ((s.re[a] == s.re[b]) ? 1 : 0);
         sum_s = ref_sin[slot] + ((s.re[a] == s.im[b]) ? 1 : 0);
         // Sticky on wrap
         if (sum_c >= ACC_MOD) begin
            ref_ovf_cos = 1'b1;
         end
         if (sum_s >= ACC_MOD) begin
            ref_ovf_sin = 1'b1;
         end
         ref_cos[slot] = sum_c % ACC_MOD;
         ref_sin[slot] = sum_s % ACC_MOD;
         e.slot     = slot_t'(slot);
         e.ovf_cos  = ref_ovf_cos;
         e.ovf_sin  = ref_ovf_sin;
         e.word.cos = accum_t'(ref_cos[slot]);
         e.word.sin = accum_t'(ref_sin[slot]);
         exp_q.push_back(e);
      end
   endfunction

   // Done when the word of the last slot is out
   task automatic wait_sweep_end();
      do begin
         @(negedge clk_x);
      end while (!(vis_valid && vis_slot == slot_t'(SLOTS - 1)));
   endtask

   task automatic send_sample(input sample_t s, input logic sw, input logic miss);
      if (sw) begin
         // Switch lands in IDLE and is held as pending
         @(posedge clk_x);
         bank_sw <= 1'b1;
         @(posedge clk_x);
         bank_sw <= 1'b0;
      end
      @(posedge clk_x);
      sample_in   <= s;
      sample_strb <= 1'b1;
      model_sweep(s, sw);
      sweeps++;
      @(posedge clk_x);
      sample_strb <= 1'b0;
      if (miss) begin
         // Mid-sweep strobe with junk bits
         @(posedge clk_x);
         sample_in   <= ~s;
         sample_strb <= 1'b1;
         exp_missed   = 1'b1;
         @(posedge clk_x);
         sample_strb <= 1'b0;
      end
      wait_sweep_end();
      check_value("missed", missed, exp_missed);
      @(posedge clk_x);
   endtask

   // ----------------------------------------
   // Output monitor
   // ----------------------------------------
   always @(negedge clk_x) begin
      exp_word_t e;
      if (!rst && vis_valid) begin
         words_seen++;
         seen_cos[vis_slot] = vis.cos;
         seen_sin[vis_slot] = vis.sin;
         if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR: vis_valid high with no word expected");
         end else begin
            e = exp_q.pop_front();
            check_value("vis_slot", vis_slot, e.slot);
            check_value($sformatf("vis.cos slot %0d", e.slot), vis.cos, e.word.cos);
            check_value($sformatf("vis.sin slot %0d", e.slot), vis.sin, e.word.sin);
            check_value("overflow_cos", overflow_cos, e.ovf_cos);
            check_value("overflow_sin", overflow_sin, e.ovf_sin);
         end
      end
   end

   // Run limit from the trace length
   always @(posedge clk_x) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("ERROR: run did not finish within %0d cycles", cycle_limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      int          fd;
      int          n_samples;
      int          cnt;
      int          sw;
      int          miss;
      int          slot;
      byte         kind;
      string       line;
      logic [23:0] re_v;
      logic [23:0] im_v;
      logic [23:0] mask;
      logic [7:0]  ecos;
      logic [7:0]  esin;
      sample_t     s;

      clk_x       = 1'b0;
      rst         = 1'b1;
      sample_strb = 1'b0;
      sample_in   = '0;
      bank_sw     = 1'b0;
      errors      = 0;
      checks      = 0;
      words_seen  = 0;
      sweeps      = 0;
      cycles      = 0;
      cycle_limit = 1000;
      lfsr_state  = 17'd86519;
      exp_missed  = 1'b0;
      ref_ovf_cos = 1'b0;
      ref_ovf_sin = 1'b0;
      // RAM starts at zero after reset
      for (int i = 0; i < SLOTS; i++) begin
         ref_cos[i]  = 0;
         ref_sin[i]  = 0;
         seen_cos[i] = '0;
         seen_sin[i] = '0;
      end

      // Load the trace and skip comments and blank lines
      n_samples = 0;
      fd = $fopen("corr_trace.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("ERROR: cannot open trace file corr_trace.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
               if ($sscanf(line, " %c", kind) == 1 && kind != "#") begin
                  trace_lines.push_back(line);
                  if (kind == "S") begin
                     n_samples++;
                  end else if (kind == "R" && $sscanf(line, "R %d", cnt) == 1) begin
                     n_samples += cnt;
                  end
               end
            end
         end
         $fclose(fd);
      end
      cycle_limit = 20 * n_samples + 200;

      repeat (4) @(posedge clk_x);
      rst <= 1'b0;

      foreach (trace_lines[i]) begin
         line = trace_lines[i];
         void'($sscanf(line, " %c", kind));
         case (kind)
            "S": begin
               void'($sscanf(line, "S %h %h %d %d", re_v, im_v, sw, miss));
               s.re = re_v;
               s.im = im_v;
               send_sample(s, sw != 0, miss != 0);
            end
            "R": begin
               void'($sscanf(line, "R %d %d %h", cnt, sw, mask));
               // Switch goes with the first sample only
               for (int k = 0; k < cnt; k++) begin
                  send_sample(random_sample(mask), (sw != 0) && (k == 0), 1'b0);
               end
            end
            "E": begin
               void'($sscanf(line, "E %h %h %h", slot, ecos, esin));
               check_value($sformatf("trace cos slot %0d", slot), seen_cos[slot], ecos);
               check_value($sformatf("trace sin slot %0d", slot), seen_sin[slot], esin);
            end
            default: begin
               errors++;
               $display("ERROR: unknown trace line %s", line);
            end
         endcase
      end

      // Drain and count
      repeat (4) @(negedge clk_x);
      if (exp_q.size() != 0) begin
         errors++;
         $display("ERROR: %0d expected vis words never appeared", exp_q.size());
      end
      check_value("vis word count", words_seen, SLOTS * sweeps);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* corr_top.sv */
module corr_top (
   input  logic              clk_x,
   input  logic              rst,
   input  logic              sample_strb,
   input  corr_pkg::sample_t sample_in,
   input  logic              bank_sw,
   output logic              vis_valid,
   output corr_pkg::slot_t   vis_slot,
   output corr_pkg::vis_t    vis,
   output logic              overflow_cos,
   output logic              overflow_sin,
   output logic              missed
);
   import corr_pkg::*;

   // ----------------------------------------
   // Controller to counter and datapath
   // ----------------------------------------
   logic    sweep_start;
   logic    sweep_clr;
   logic    sweep_done;
   sample_t held_sample;

   // Counter to datapath
   logic    slot_en;
   slot_t   rd_slot;
   slot_t   wr_slot;

   corr_ctrl_fsm u_corr_ctrl_fsm (
      .clk_x       (clk_x),
      .rst         (rst),
      .sample_strb (sample_strb),
      .sample_in   (sample_in),
      .bank_sw     (bank_sw),
      .sweep_done  (sweep_done),
      .sweep_start (sweep_start),
      .sweep_clr   (sweep_clr),
      .held_sample (held_sample),
      .missed      (missed)
   );

   corr_slot_counter u_corr_slot_counter (
      .clk_x       (clk_x),
      .rst         (rst),
      .sweep_start (sweep_start),
      .rd_slot     (rd_slot),
      .slot_en     (slot_en),
      .wr_slot     (wr_slot),
      .sweep_done  (sweep_done)
   );

   correlator_block u_correlator_block (
      .clk_x        (clk_x),
      .rst          (rst),
      .held_sample  (held_sample),
      .sweep_clr    (sweep_clr),
      .slot_en      (slot_en),
      .rd_slot      (rd_slot),
      .wr_slot      (wr_slot),
      .vis_valid    (vis_valid),
      .vis_slot     (vis_slot),
      .vis          (vis),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

endmodule

/* corr_trace.txt */
# S re im sw miss : sample bits in hex, sw pulses bank_sw first, miss adds a mid-sweep strobe
# R count sw mask : count LFSR samples ANDed with the hex mask, sw on the first one only
# E slot cos sin  : last cos and sin words written for the slot, all hex
#
# Running counts from reset
S 000000 000000 0 0
S ffffff ffffff 0 0
E 0 02 02
E 6 02 02
E b 02 02
S ffffff 000000 0 0
E 3 03 02
# Antenna 0 disagrees alone, the extra strobe is dropped
S 000001 000000 0 1
E 0 03 02
E 1 03 02
E 2 04 03
E b 04 03
# Bank switch restarts every pair from this sample
S 000000 ffffff 1 0
E 0 01 00
E 5 01 00
E b 01 00
# Later sweeps add to the restarted values
S 000000 000000 0 0
E 7 02 01
# All-match run wraps both accumulators
R 260 0 000000
E 0 06 05
E a 06 05
E b 06 05
# Random samples, the switch clears the overflow flags
R 20 1 ffffff
R 8 0 ffffff
S 000000 000000 0 0

/* correlator_block.sv */
`include "corr_consts.svh"

module correlator_block (
   input  logic              clk_x,
   input  logic              rst,
   input  corr_pkg::sample_t held_sample,
   input  logic              sweep_clr,
   input  logic              slot_en,
   input  corr_pkg::slot_t   rd_slot,
   input  corr_pkg::slot_t   wr_slot,
   output logic              vis_valid,
   output corr_pkg::slot_t   vis_slot,
   output corr_pkg::vis_t    vis,
   output logic              overflow_cos,
   output logic              overflow_sin
);
   import corr_pkg::*;

   localparam int SLOTS     = `CORR_SLOTS;
   localparam int PAIR_BITS = $bits(pair_t);
   localparam logic [SLOTS*PAIR_BITS-1:0] PAIR_TABLE = `CORR_PAIRS;

   // Cos and sin accumulators share one word per slot
   vis_t   acc_ram [0:SLOTS-1];
   vis_t   rd_word;
   pair_t  pair;
   logic   ar;
   logic   br;
   logic   bi;
   logic   slot_en_q;
   accum_t qcos;
   accum_t qsin;

   // ----------------------------------------
   // Pair selection
   // ----------------------------------------
   // Table entry for the slot being read
   assign pair = PAIR_TABLE[rd_slot*PAIR_BITS +: PAIR_BITS];

   // Real bit of a, real and imaginary bits of b
   assign ar = held_sample.re[pair.a];
   assign br = held_sample.re[pair.b];
   assign bi = held_sample.im[pair.b];

   // ----------------------------------------
   // Accumulator RAM
   // ----------------------------------------
   // Asynchronous read in the slot_en cycle
   assign rd_word = acc_ram[rd_slot];

   // Write-back two cycles behind the read
   always_ff @(posedge clk_x) begin
      if (rst) begin
         for (int i = 0; i < SLOTS; i++) begin
            acc_ram[i] <= '0;
         end
      end else if (vis_valid) begin
         acc_ram[wr_slot] <= vis;
      end
   end

   // ----------------------------------------
   // Adders and overflow flags
   // ----------------------------------------
   corr_accumulate u_corr_accumulate (
      .clk_x        (clk_x),
      .rst          (rst),
      .go           (slot_en),
      .clr          (sweep_clr),
      .ar           (ar),
      .br           (br),
      .bi           (bi),
      .dcos         (rd_word.cos),
      .dsin         (rd_word.sin),
      .qcos         (qcos),
      .qsin         (qsin),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   // ----------------------------------------
   // Valid alignment
   // ----------------------------------------
   // One stage for the operand registers, one for the sums
   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot_en_q <= 1'b0;
         vis_valid <= 1'b0;
      end else begin
         slot_en_q <= slot_en;
         vis_valid <= slot_en_q;
      end
   end

   // Output word is the value being written back
   assign vis      = '{sin: qsin, cos: qcos};
   assign vis_slot = wr_slot;

endmodule

/* verilog.f */
+incdir+.
corr_pkg.sv
corr_ctrl_fsm.sv
corr_slot_counter.sv
corr_accumulate.sv
correlator_block.sv
corr_top.sv
corr_assertions.sv
corr_tb.sv
